/* Bender.yml */
package:
  name: dcache

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - dcache_pkg.sv
      - dcache_way_ram.sv
      - dcache_repl_state.sv
      - dcache_data_align.sv
      - dcache_writeback.sv
      - dcache_ctrl.sv
      - dcache_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_dcache.sv

/* dcache.f */
+incdir+.
dcache_pkg.sv
dcache_way_ram.sv
dcache_repl_state.sv
dcache_data_align.sv
dcache_writeback.sv
dcache_ctrl.sv
dcache_top.sv
tb_dcache.sv

/* dcache_config.svh */
`ifndef DCACHE_CONFIG_SVH
`define DCACHE_CONFIG_SVH

// set index bits and set count
`define DCACHE_INDEX_W 6
`define DCACHE_SETS 64

// byte offset within one line
`define DCACHE_OFFSET_W 6
`define DCACHE_LINE_BYTES 64

// one line is also one memory beat
`define DCACHE_LINE_W 512

// address bits left above index and offset
`define DCACHE_TAG_W 20

`endif

/* dcache_ctrl.sv */
`timescale 1ns/1ps
`include "dcache_config.svh"

module dcache_ctrl (
    input  logic                          clk,
    input  logic                          rstn,
    input  logic                          i_req_valid,
    input  logic                          i_req_write,
    input  logic [31:0]                   i_req_addr,
    input  dcache_pkg::access_size_e      i_req_size,
    input  logic                          i_req_signed,
    input  logic [31:0]                   i_req_wdata,
    output logic                          o_ready,
    output logic                          o_resp_valid,
    output logic [31:0]                   o_resp_rdata,
    output logic                          o_mem_rd_valid,
    input  logic                          i_mem_rd_ready,
    output logic [31:0]                   o_mem_rd_addr,
    input  logic [`DCACHE_LINE_W-1:0]     i_mem_rd_data,
    output logic [`DCACHE_INDEX_W-1:0]    o_index,
    input  logic                          i_way0_valid,
    input  logic [`DCACHE_TAG_W-1:0]      i_way0_tag,
    input  logic [`DCACHE_LINE_W-1:0]     i_way0_line,
    input  logic                          i_way1_valid,
    input  logic [`DCACHE_TAG_W-1:0]      i_way1_tag,
    input  logic [`DCACHE_LINE_W-1:0]     i_way1_line,
    output logic [`DCACHE_LINE_BYTES-1:0] o_way0_byte_en,
    output logic [`DCACHE_LINE_BYTES-1:0] o_way1_byte_en,
    output logic                          o_way0_tag_we,
    output logic                          o_way1_tag_we,
    output logic [`DCACHE_LINE_W-1:0]     o_wr_line,
    output logic [`DCACHE_TAG_W-1:0]      o_wr_tag,
    output logic                          o_touch,
    output logic                          o_touch_way,
    output logic                          o_dirty_we,
    output logic                          o_dirty_way,
    output logic                          o_dirty_val,
    input  logic                          i_victim_way,
    input  logic [1:0]                    i_dirty,
    output logic [`DCACHE_OFFSET_W-1:0]   o_offset,
    output dcache_pkg::access_size_e      o_size,
    output logic                          o_signed,
    output logic                          o_write,
    output logic [31:0]                   o_wdata,
    output logic [`DCACHE_LINE_W-1:0]     o_sel_line,
    output logic [`DCACHE_LINE_W-1:0]     o_refill_line,
    input  logic [31:0]                   i_rdata,
    input  logic [`DCACHE_LINE_BYTES-1:0] i_byte_en,
    input  logic [`DCACHE_LINE_W-1:0]     i_store_line,
    input  logic [`DCACHE_LINE_W-1:0]     i_merged_line,
    output logic                          o_wb_start,
    output logic                          o_wb_dirty,
    output logic [`DCACHE_LINE_W-1:0]     o_wb_line,
    output logic [31:0]                   o_wb_addr,
    output logic                          o_wb_ack,
    input  logic                          i_wb_done
);

    dcache_pkg::ctrl_state_e state_q, state_d;
    logic [31:0]               req_addr;
    logic [`DCACHE_TAG_W-1:0]  req_tag;
    logic [`DCACHE_LINE_W-1:0] refill_buf;
    logic                      hit0, hit1, hit, in_lookup, in_refill;

    // request buffer, payload only
    always_ff @(posedge clk) begin
        if (i_req_valid && o_ready) begin
            req_addr <= i_req_addr;
            o_write  <= i_req_write;
            o_size   <= i_req_size;
            o_signed <= i_req_signed;
            o_wdata  <= i_req_wdata;
        end
        if (o_mem_rd_valid && i_mem_rd_ready) refill_buf <= i_mem_rd_data;
    end

    always_ff @(posedge clk) begin
        if (!rstn) state_q <= dcache_pkg::IDLE;
        else       state_q <= state_d;
    end

    assign req_tag   = req_addr[31 -: `DCACHE_TAG_W];
    assign in_lookup = (state_q == dcache_pkg::LOOKUP);
    assign in_refill = (state_q == dcache_pkg::REFILL);
    assign hit0      = i_way0_valid && (i_way0_tag == req_tag);
    assign hit1      = i_way1_valid && (i_way1_tag == req_tag);
    assign hit       = hit0 || hit1;

    always_comb begin
        state_d = state_q;
        case (state_q)
            dcache_pkg::IDLE:    if (i_req_valid) state_d = dcache_pkg::LOOKUP;
            dcache_pkg::LOOKUP:  state_d = hit ? dcache_pkg::IDLE : dcache_pkg::MISS;
            dcache_pkg::MISS:    if (i_mem_rd_ready) state_d = dcache_pkg::REFILL;
            dcache_pkg::REFILL:  state_d = dcache_pkg::WAIT_WB;
            dcache_pkg::WAIT_WB: if (i_wb_done) state_d = dcache_pkg::IDLE;
            default:             state_d = dcache_pkg::IDLE;
        endcase
    end

    // idle reads the incoming index so lookup has the ways one cycle later
    assign o_index = (state_q == dcache_pkg::IDLE) ? i_req_addr[`DCACHE_OFFSET_W +: `DCACHE_INDEX_W]
                                                   : req_addr[`DCACHE_OFFSET_W +: `DCACHE_INDEX_W];

    assign o_ready        = (state_q == dcache_pkg::IDLE);
    assign o_resp_valid   = (in_lookup && hit) || (state_q == dcache_pkg::WAIT_WB && i_wb_done);
    assign o_resp_rdata   = i_rdata;
    assign o_mem_rd_valid = (state_q == dcache_pkg::MISS);
    assign o_mem_rd_addr  = {req_addr[31:`DCACHE_OFFSET_W], {`DCACHE_OFFSET_W{1'b0}}};

    // way writes: strobed store on a hit, full line on refill
    assign o_way0_byte_en = (in_lookup && hit0 && o_write) ? i_byte_en :
                            (in_refill && !i_victim_way) ? '1 : '0;
    assign o_way1_byte_en = (in_lookup && hit1 && o_write) ? i_byte_en :
                            (in_refill && i_victim_way) ? '1 : '0;
    assign o_way0_tag_we  = in_refill && !i_victim_way;
    assign o_way1_tag_we  = in_refill && i_victim_way;
    assign o_wr_line      = in_refill ? i_merged_line : i_store_line;
    assign o_wr_tag       = req_tag;

    assign o_touch     = (in_lookup && hit) || in_refill;
    assign o_touch_way = in_refill ? i_victim_way : hit1;
    assign o_dirty_we  = (in_lookup && hit && o_write) || in_refill;
    assign o_dirty_way = o_touch_way;
    assign o_dirty_val = o_write;   // refill of a load leaves it clean

    assign o_offset      = req_addr[`DCACHE_OFFSET_W-1:0];
    assign o_sel_line    = in_lookup ? (hit1 ? i_way1_line : i_way0_line) : refill_buf;
    assign o_refill_line = refill_buf;

    // victim handed over on the lookup miss
    assign o_wb_start = in_lookup && !hit;
    assign o_wb_dirty = i_dirty[i_victim_way];
    assign o_wb_line  = i_victim_way ? i_way1_line : i_way0_line;
    assign o_wb_addr  = {(i_victim_way ? i_way1_tag : i_way0_tag),
                         req_addr[`DCACHE_OFFSET_W +: `DCACHE_INDEX_W], {`DCACHE_OFFSET_W{1'b0}}};
    assign o_wb_ack   = (state_q == dcache_pkg::WAIT_WB) && i_wb_done;

    assert property (@(posedge clk) disable iff (!rstn)
        (i_req_valid && o_ready) |->
            ((i_req_size != dcache_pkg::SIZE_HALF || !i_req_addr[0]) &&
             (i_req_size != dcache_pkg::SIZE_WORD || i_req_addr[1:0] == 2'b00)));

endmodule

/* dcache_data_align.sv */
`timescale 1ns/1ps
`include "dcache_config.svh"

module dcache_data_align (
    input  logic [`DCACHE_OFFSET_W-1:0]   i_offset,
    input  dcache_pkg::access_size_e      i_size,
    input  logic                          i_signed,
    input  logic                          i_write,
    input  logic [31:0]                   i_wdata,
    input  logic [`DCACHE_LINE_W-1:0]     i_line,
    input  logic [`DCACHE_LINE_W-1:0]     i_refill_line,
    output logic [31:0]                   o_rdata,
    output logic [`DCACHE_LINE_BYTES-1:0] o_byte_en,
    output logic [`DCACHE_LINE_W-1:0]     o_store_line,
    output logic [`DCACHE_LINE_W-1:0]     o_merged_line
);

    logic [31:0] word;
    logic [7:0]  byte_v;
    logic [15:0] half_v;
    logic [3:0]  be4;
    logic [31:0] wrep;

    assign word   = i_line[{i_offset[5:2], 5'b0} +: 32];
    assign byte_v = word[{i_offset[1:0], 3'b0} +: 8];
    assign half_v = word[{i_offset[1], 4'b0} +: 16];

    always_comb begin
        case (i_size)
            dcache_pkg::SIZE_BYTE: begin
                o_rdata = {{24{i_signed & byte_v[7]}}, byte_v};
                be4     = 4'b0001;
                wrep    = {4{i_wdata[7:0]}};   // every lane carries the byte
            end
            dcache_pkg::SIZE_HALF: begin
                o_rdata = {{16{i_signed & half_v[15]}}, half_v};
                be4     = 4'b0011;
                wrep    = {2{i_wdata[15:0]}};
            end
            default: begin
                o_rdata = word;
                be4     = 4'b1111;
                wrep    = i_wdata;
            end
        endcase
    end

    // strobes pick the right lane out of the replicated data
    assign o_byte_en    = {{(`DCACHE_LINE_BYTES-4){1'b0}}, be4} << i_offset;
    assign o_store_line = {(`DCACHE_LINE_BYTES/4){wrep}};

    for (genvar b = 0; b < `DCACHE_LINE_BYTES; b++) begin : g_merge
        assign o_merged_line[b*8 +: 8] = (i_write && o_byte_en[b]) ? o_store_line[b*8 +: 8]
                                                                    : i_refill_line[b*8 +: 8];
    end

endmodule

/* dcache_pkg.sv */
package dcache_pkg;

    // access size of a load or store
    typedef enum logic [1:0] {
        SIZE_BYTE = 2'd0,
        SIZE_HALF = 2'd1,
        SIZE_WORD = 2'd2
    } access_size_e;

    // main controller states
    typedef enum logic [2:0] {
        IDLE    = 3'd0,
        LOOKUP  = 3'd1,
        MISS    = 3'd2, // line read outstanding
        REFILL  = 3'd3,
        WAIT_WB = 3'd4
    } ctrl_state_e;

    // write-back engine states
    typedef enum logic [1:0] {
        WB_INIT   = 2'd0,
        WB_WRITE  = 2'd1,
        WB_FINISH = 2'd2
    } wb_state_e;

endpackage

/* dcache_repl_state.sv */
`timescale 1ns/1ps
`include "dcache_config.svh"

module dcache_repl_state (
    input  logic                       clk,
    input  logic                       rstn,
    input  logic [`DCACHE_INDEX_W-1:0] i_index,
    input  logic                       i_touch,
    input  logic                       i_touch_way,
    output logic                       o_victim_way,
    input  logic                       i_dirty_we,
    input  logic                       i_dirty_way,
    input  logic                       i_dirty_val,
    output logic [1:0]                 o_dirty
);

    logic [`DCACHE_SETS-1:0] mru_q;    // most recently used way per set
    logic [1:0]              dirty_q [`DCACHE_SETS];

    always_ff @(posedge clk) begin
        if (!rstn) begin
            mru_q <= '0;
            for (int s = 0; s < `DCACHE_SETS; s++) dirty_q[s] <= 2'b00;
        end else begin
            if (i_touch) mru_q[i_index] <= i_touch_way;
            if (i_dirty_we) dirty_q[i_index][i_dirty_way] <= i_dirty_val;
        end
    end

    assign o_victim_way = ~mru_q[i_index];
    assign o_dirty      = dirty_q[i_index];

    // a touch or dirty update always names a known way
    assert property (@(posedge clk) disable iff (!rstn)
        (i_touch || i_dirty_we) |-> !$isunknown({i_touch_way, i_dirty_way}));

endmodule

/* dcache_top.sv */
`timescale 1ns/1ps
`include "dcache_config.svh"

module dcache_top (
    input  logic                      clk,
    input  logic                      rstn,
    input  logic                      i_req_valid,
    input  logic                      i_req_write,
    input  logic [31:0]               i_req_addr,
    input  dcache_pkg::access_size_e  i_req_size,
    input  logic                      i_req_signed,
    input  logic [31:0]               i_req_wdata,
    output logic                      o_ready,
    output logic                      o_resp_valid,
    output logic [31:0]               o_resp_rdata,
    output logic                      o_mem_rd_valid,
    input  logic                      i_mem_rd_ready,
    output logic [31:0]               o_mem_rd_addr,
    input  logic [`DCACHE_LINE_W-1:0] i_mem_rd_data,
    output logic                      o_mem_wr_valid,
    input  logic                      i_mem_wr_ready,
    output logic [31:0]               o_mem_wr_addr,
    output logic [`DCACHE_LINE_W-1:0] o_mem_wr_data
);

    logic [`DCACHE_INDEX_W-1:0]    index;
    logic                          way0_valid, way1_valid;
    logic [`DCACHE_TAG_W-1:0]      way0_tag, way1_tag, wr_tag;
    logic [`DCACHE_LINE_W-1:0]     way0_line, way1_line, wr_line;
    logic [`DCACHE_LINE_BYTES-1:0] way0_byte_en, way1_byte_en, byte_en;
    logic                          way0_tag_we, way1_tag_we;
    logic                          touch, touch_way, dirty_we, dirty_way, dirty_val;
    logic                          victim_way;
    logic [1:0]                    dirty;
    logic [`DCACHE_OFFSET_W-1:0]   offset;
    dcache_pkg::access_size_e      size;
    logic                          sign_ext, write;
    logic [31:0]                   wdata, rdata, wb_addr;
    logic [`DCACHE_LINE_W-1:0]     sel_line, refill_line, store_line, merged_line, wb_line;
    logic                          wb_start, wb_dirty, wb_ack, wb_done;

    dcache_ctrl ctrl_i (
        .clk, .rstn,
        .i_req_valid, .i_req_write, .i_req_addr, .i_req_size, .i_req_signed, .i_req_wdata,
        .o_ready, .o_resp_valid, .o_resp_rdata,
        .o_mem_rd_valid, .i_mem_rd_ready, .o_mem_rd_addr, .i_mem_rd_data,
        .o_index(index),
        .i_way0_valid(way0_valid), .i_way0_tag(way0_tag), .i_way0_line(way0_line),
        .i_way1_valid(way1_valid), .i_way1_tag(way1_tag), .i_way1_line(way1_line),
        .o_way0_byte_en(way0_byte_en), .o_way1_byte_en(way1_byte_en),
        .o_way0_tag_we(way0_tag_we), .o_way1_tag_we(way1_tag_we),
        .o_wr_line(wr_line), .o_wr_tag(wr_tag),
        .o_touch(touch), .o_touch_way(touch_way),
        .o_dirty_we(dirty_we), .o_dirty_way(dirty_way), .o_dirty_val(dirty_val),
        .i_victim_way(victim_way), .i_dirty(dirty),
        .o_offset(offset), .o_size(size), .o_signed(sign_ext), .o_write(write),
        .o_wdata(wdata), .o_sel_line(sel_line), .o_refill_line(refill_line),
        .i_rdata(rdata), .i_byte_en(byte_en), .i_store_line(store_line),
        .i_merged_line(merged_line),
        .o_wb_start(wb_start), .o_wb_dirty(wb_dirty), .o_wb_line(wb_line),
        .o_wb_addr(wb_addr), .o_wb_ack(wb_ack), .i_wb_done(wb_done)
    );

    dcache_way_ram way0_i (
        .clk, .rstn, .i_rd_index(index),
        .o_rd_valid(way0_valid), .o_rd_tag(way0_tag), .o_rd_line(way0_line),
        .i_wr_index(index), .i_wr_byte_en(way0_byte_en), .i_wr_line(wr_line),
        .i_tag_we(way0_tag_we), .i_wr_tag(wr_tag)
    );

    dcache_way_ram way1_i (
        .clk, .rstn, .i_rd_index(index),
        .o_rd_valid(way1_valid), .o_rd_tag(way1_tag), .o_rd_line(way1_line),
        .i_wr_index(index), .i_wr_byte_en(way1_byte_en), .i_wr_line(wr_line),
        .i_tag_we(way1_tag_we), .i_wr_tag(wr_tag)
    );

    dcache_repl_state repl_i (
        .clk, .rstn, .i_index(index),
        .i_touch(touch), .i_touch_way(touch_way), .o_victim_way(victim_way),
        .i_dirty_we(dirty_we), .i_dirty_way(dirty_way), .i_dirty_val(dirty_val),
        .o_dirty(dirty)
    );

    dcache_data_align align_i (
        .i_offset(offset), .i_size(size), .i_signed(sign_ext), .i_write(write),
        .i_wdata(wdata), .i_line(sel_line), .i_refill_line(refill_line),
        .o_rdata(rdata), .o_byte_en(byte_en), .o_store_line(store_line),
        .o_merged_line(merged_line)
    );

    dcache_writeback wb_i (
        .clk, .rstn,
        .i_start(wb_start), .i_dirty(wb_dirty), .i_line(wb_line), .i_addr(wb_addr),
        .i_ack(wb_ack), .o_done(wb_done),
        .o_mem_wr_valid, .i_mem_wr_ready, .o_mem_wr_addr, .o_mem_wr_data
    );

endmodule

/* dcache_way_ram.sv */
`timescale 1ns/1ps
`include "dcache_config.svh"

module dcache_way_ram (
    input  logic                          clk,
    input  logic                          rstn,
    input  logic [`DCACHE_INDEX_W-1:0]    i_rd_index,
    output logic                          o_rd_valid,
    output logic [`DCACHE_TAG_W-1:0]      o_rd_tag,
    output logic [`DCACHE_LINE_W-1:0]     o_rd_line,
    input  logic [`DCACHE_INDEX_W-1:0]    i_wr_index,
    input  logic [`DCACHE_LINE_BYTES-1:0] i_wr_byte_en,
    input  logic [`DCACHE_LINE_W-1:0]     i_wr_line,
    input  logic                          i_tag_we,
    input  logic [`DCACHE_TAG_W-1:0]      i_wr_tag
);

    logic [`DCACHE_LINE_W-1:0] line_mem [`DCACHE_SETS];
    logic [`DCACHE_TAG_W-1:0]  tag_mem  [`DCACHE_SETS];
    logic [`DCACHE_SETS-1:0]   valid_q;

    always_ff @(posedge clk) begin
        for (int b = 0; b < `DCACHE_LINE_BYTES; b++) begin
            if (i_wr_byte_en[b]) line_mem[i_wr_index][b*8 +: 8] <= i_wr_line[b*8 +: 8];
        end
        if (i_tag_we) tag_mem[i_wr_index] <= i_wr_tag;
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            valid_q <= '0;
        end else if (i_tag_we) begin
            valid_q[i_wr_index] <= 1'b1; // a new tag makes the line live
        end
    end

    // registered read, old data on a same-cycle write
    always_ff @(posedge clk) begin
        o_rd_valid <= valid_q[i_rd_index];
        o_rd_tag   <= tag_mem[i_rd_index];
        o_rd_line  <= line_mem[i_rd_index];
    end

endmodule

/* dcache_writeback.sv */
`timescale 1ns/1ps
`include "dcache_config.svh"

module dcache_writeback (
    input  logic                      clk,
    input  logic                      rstn,
    input  logic                      i_start,
    input  logic                      i_dirty,
    input  logic [`DCACHE_LINE_W-1:0] i_line,
    input  logic [31:0]               i_addr,
    input  logic                      i_ack,
    output logic                      o_done,
    output logic                      o_mem_wr_valid,
    input  logic                      i_mem_wr_ready,
    output logic [31:0]               o_mem_wr_addr,
    output logic [`DCACHE_LINE_W-1:0] o_mem_wr_data
);

    dcache_pkg::wb_state_e state_q, state_d;
    logic started_q;   // start seen last cycle
    logic dirty_q;

    always_ff @(posedge clk) begin
        if (i_start) begin
            o_mem_wr_data <= i_line;
            o_mem_wr_addr <= i_addr;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state_q   <= dcache_pkg::WB_INIT;
            started_q <= 1'b0;
            dirty_q   <= 1'b0;
        end else begin
            state_q   <= state_d;
            started_q <= i_start;
            if (i_start) dirty_q <= i_dirty;
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            dcache_pkg::WB_INIT:   if (started_q) state_d = dirty_q ? dcache_pkg::WB_WRITE
                                                                    : dcache_pkg::WB_FINISH;
            dcache_pkg::WB_WRITE:  if (i_mem_wr_ready) state_d = dcache_pkg::WB_FINISH;
            dcache_pkg::WB_FINISH: if (i_ack) state_d = dcache_pkg::WB_INIT;
            default:               state_d = dcache_pkg::WB_INIT;
        endcase
    end

    assign o_mem_wr_valid = (state_q == dcache_pkg::WB_WRITE);
    assign o_done         = (state_q == dcache_pkg::WB_FINISH);

    // payload frozen until memory takes it
    assert property (@(posedge clk) disable iff (!rstn)
        (o_mem_wr_valid && !i_mem_wr_ready) |=>
            (o_mem_wr_valid && $stable(o_mem_wr_addr) && $stable(o_mem_wr_data)));

endmodule

/* tb_dcache.sv */
`timescale 1ns/1ps
`include "dcache_config.svh"

module tb_dcache;

    localparam int      NUM_REQS   = 3000;
    localparam int      DIRECTED   = 5;
    localparam int      MAX_DELAY  = 5;    // memory ready delay in cycles
    localparam int      RESP_LIMIT = 200;
    localparam realtime CLK_PERIOD = 4.0;
    localparam realtime DRIVE_DLY  = 0.5;

    logic                      clk, rstn;
    logic                      i_req_valid, i_req_write, i_req_signed;
    logic [31:0]               i_req_addr, i_req_wdata;
    dcache_pkg::access_size_e  i_req_size;
    logic                      o_ready, o_resp_valid;
    logic [31:0]               o_resp_rdata;
    logic                      o_mem_rd_valid, i_mem_rd_ready;
    logic [31:0]               o_mem_rd_addr;
    logic [`DCACHE_LINE_W-1:0] i_mem_rd_data;
    logic                      o_mem_wr_valid, i_mem_wr_ready;
    logic [31:0]               o_mem_wr_addr;
    logic [`DCACHE_LINE_W-1:0] o_mem_wr_data;

    logic [`DCACHE_LINE_W-1:0] mem_lines [logic [31:0]];   // backing memory holds written lines
    logic [7:0]                ref_bytes [logic [31:0]];   // architectural memory
    bit                        stored_lines [logic [31:0]];
    logic [31:0]               req_line = '0;               // line of the request in flight
    integer                    seed = 32'h63183c1f;
    int                        errors = 0;
    int                        checks = 0;
    int                        rd_count = 0;

    dcache_top dcache_top_i (.*);

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [31:0] word_hash(input logic [31:0] a);
        logic [31:0] h;
        h = a ^ 32'h2545f491;
        h = h * 32'h9e3779b1;
        return h ^ (h >> 15);
    endfunction

    function automatic logic [`DCACHE_LINE_W-1:0] line_fetch(input logic [31:0] la);
        logic [`DCACHE_LINE_W-1:0] l;
        if (mem_lines.exists(la)) return mem_lines[la];
        for (int w = 0; w < `DCACHE_LINE_BYTES / 4; w++) l[w*32 +: 32] = word_hash(la + 4 * w);
        return l;
    endfunction

    function automatic logic [7:0] ref_byte(input logic [31:0] a);
        logic [31:0] w;
        if (ref_bytes.exists(a)) return ref_bytes[a];
        w = word_hash({a[31:2], 2'b00});
        return w[a[1:0]*8 +: 8];
    endfunction

    function automatic logic [`DCACHE_LINE_W-1:0] ref_line(input logic [31:0] la);
        logic [`DCACHE_LINE_W-1:0] l;
        for (int b = 0; b < `DCACHE_LINE_BYTES; b++) l[b*8 +: 8] = ref_byte(la + b);
        return l;
    endfunction

    // little endian with extension by size
    function automatic logic [31:0] expected_load(input logic [31:0] a, input logic [1:0] sz,
                                                  input logic sgn);
        logic [31:0] v;
        v = {ref_byte(a + 3), ref_byte(a + 2), ref_byte(a + 1), ref_byte(a)};
        case (sz)
            2'd0:    return {{24{sgn & v[7]}}, v[7:0]};
            2'd1:    return {{16{sgn & v[15]}}, v[15:0]};
            default: return v;
        endcase
    endfunction

    task automatic report_mismatch(input string what, input logic [31:0] got,
                                   input logic [31:0] exp);
        errors++;
        $display("FAILED at %0t: %s, got %h expected %h", $time, what, got, exp);
    endtask

    // called and returns just after a rising edge
    task automatic run_access(input logic wr, input logic [31:0] addr, input logic [1:0] sz,
                              input logic sgn, input logic [31:0] wdata);
        logic [31:0] exp;
        int          waited;
        exp          = expected_load(addr, sz, sgn);
        req_line     = {addr[31:6], 6'b0};
        i_req_valid  = 1'b1;
        i_req_write  = wr;
        i_req_addr   = addr;
        i_req_size   = dcache_pkg::access_size_e'(sz);
        i_req_signed = sgn;
        i_req_wdata  = wdata;
        do @(negedge clk); while (o_ready !== 1'b1);
        if (o_resp_valid !== 1'b0) begin
            errors++;
            $display("response valid while no request was pending, at %0t", $time);
        end
        @(posedge clk);   // accepted here
        #(DRIVE_DLY);
        i_req_valid = 1'b0;
        waited = 0;
        @(negedge clk);
        while (o_resp_valid !== 1'b1 && waited < RESP_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (waited >= RESP_LIMIT) begin
            errors++;
            $display("no response to request at address %h by %0t", addr, $time);
        end else if (!wr) begin
            checks++;
            if (o_resp_rdata !== exp)
                report_mismatch($sformatf("load %h", addr), o_resp_rdata, exp);
        end else begin
            for (int b = 0; b < (1 << sz); b++) ref_bytes[addr + b] = wdata[b*8 +: 8];
            stored_lines[{addr[31:6], 6'b0}] = 1'b1;
        end
        @(posedge clk);
        #(DRIVE_DLY);
    endtask

    // line read port with random ready delay
    initial begin : mem_read_responder
        logic [31:0] addr;
        int          delay;
        forever begin
            @(negedge clk);
            if (o_mem_rd_valid === 1'b1) begin
                addr = o_mem_rd_addr;
                checks++;
                if (addr !== req_line) report_mismatch("read line address", addr, req_line);
                delay = {$random(seed)} % (MAX_DELAY + 1);
                repeat (delay) begin
                    @(negedge clk);
                    if (o_mem_rd_valid !== 1'b1 || o_mem_rd_addr !== addr ||
                        o_ready !== 1'b0) begin
                        errors++;
                        $display("read request not held while memory stalled, at %0t", $time);
                    end
                end
                @(posedge clk);
                #(DRIVE_DLY);
                i_mem_rd_ready = 1'b1;
                i_mem_rd_data  = line_fetch(addr);
                rd_count++;
                @(posedge clk);
                #(DRIVE_DLY);
                i_mem_rd_ready = 1'b0;
            end
        end
    end

    initial begin : mem_write_responder
        logic [31:0]               addr;
        logic [`DCACHE_LINE_W-1:0] data;
        int                        delay;
        forever begin
            @(negedge clk);
            if (o_mem_wr_valid === 1'b1) begin
                addr = o_mem_wr_addr;
                data = o_mem_wr_data;
                checks++;
                if (addr[5:0] !== 6'd0) report_mismatch("write address alignment", addr,
                                                        {addr[31:6], 6'b0});
                if (!stored_lines.exists(addr)) begin
                    errors++;
                    $display("write-back of line %h that was never stored to, at %0t",
                             addr, $time);
                end
                if (data !== ref_line(addr)) begin
                    errors++;
                    $display("FAILED at %0t: write-back data of line %h differs from reference",
                             $time, addr);
                end
                delay = {$random(seed)} % (MAX_DELAY + 1);
                repeat (delay) begin
                    @(negedge clk);
                    if (o_mem_wr_valid !== 1'b1 || o_mem_wr_addr !== addr ||
                        o_mem_wr_data !== data || o_ready !== 1'b0) begin
                        errors++;
                        $display("write request not held while memory stalled, at %0t", $time);
                    end
                end
                @(posedge clk);
                #(DRIVE_DLY);
                i_mem_wr_ready = 1'b1;
                mem_lines[addr] = data;
                @(posedge clk);
                #(DRIVE_DLY);
                i_mem_wr_ready = 1'b0;
            end
        end
    end

    initial begin : watchdog
        #((NUM_REQS + DIRECTED + 16) * 40 * CLK_PERIOD);
        $display("timeout: the run did not complete in time");
        $display("summary: %0d checks, %0d errors", checks, errors);
        $display("FAIL: see errors above");
        $finish;
    end

    initial begin : main
        logic [31:0] a_addr, b_addr, c_addr, addr, r, tag_idx, sz;
        logic [19:0] tag;
        logic [5:0]  off;
        int          rd_before;
        rstn           = 1'b0;
        i_req_valid    = 1'b0;
        i_req_write    = 1'b0;
        i_req_addr     = '0;
        i_req_size     = dcache_pkg::SIZE_WORD;
        i_req_signed   = 1'b0;
        i_req_wdata    = '0;
        i_mem_rd_ready = 1'b0;
        i_mem_rd_data  = '0;
        i_mem_wr_ready = 1'b0;
        repeat (16) @(posedge clk);
        #(DRIVE_DLY);
        rstn = 1'b1;
        @(negedge clk);
        checks++;
        if ({o_ready, o_resp_valid, o_mem_rd_valid, o_mem_wr_valid} !== 4'b1000)
            report_mismatch("ready and valids after reset",
                            {o_ready, o_resp_valid, o_mem_rd_valid, o_mem_wr_valid}, 4'b1000);
        @(posedge clk);
        #(DRIVE_DLY);

        // LRU order A, B, A before C evicts B
        a_addr = {20'h00777, 6'd20, 6'd0};
        b_addr = {20'h00888, 6'd20, 6'd4};
        c_addr = {20'h00999, 6'd20, 6'd8};
        run_access(1'b0, a_addr, 2'd2, 1'b0, 32'h0);
        run_access(1'b0, b_addr, 2'd2, 1'b0, 32'h0);
        rd_before = rd_count;
        run_access(1'b0, a_addr, 2'd2, 1'b0, 32'h0);
        checks++;
        if (rd_count != rd_before) report_mismatch("reads on re-access of A", rd_count, rd_before);
        rd_before = rd_count;
        run_access(1'b0, c_addr, 2'd2, 1'b0, 32'h0);
        run_access(1'b0, b_addr, 2'd2, 1'b0, 32'h0);
        checks++;
        if (rd_count != rd_before + 2)
            report_mismatch("reads for C then evicted B", rd_count, rd_before + 2);

        // random mix over 8 sets with 6 tags each
        for (int n = 0; n < NUM_REQS; n++) begin
            r       = $random(seed);
            tag_idx = {$random(seed)} % 6;
            sz      = {$random(seed)} % 3;
            off     = r[8:3];
            if (sz == 1) off[0] = 1'b0;
            if (sz == 2) off[1:0] = 2'b00;
            tag  = 20'h00a40 + tag_idx[19:0] * 20'h00111;
            addr = {tag, 3'b000, r[2:0], off};
            run_access(r[11:9] < 3'd3, addr, sz[1:0], r[12], $random(seed));
        end

        $display("summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule
